// ==== flist.f ====
+incdir+include
hdl/sound_types_pkg.sv
hdl/sound_bus_pkg.sv
hdl/axil_arbiter.sv
hdl/sound_regs.sv
hdl/sn76477_core.sv
hdl/sound_io_top.sv
verification/tb_sound_io.sv

// ==== hdl/axil_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sound_consts.svh"

module axil_arbiter (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      p0_awvalid,
    output logic                           p0_awready,
    input  wire sound_bus_pkg::bus_addr_t  p0_awaddr,
    input  wire logic                      p0_wvalid,
    output logic                           p0_wready,
    input  wire sound_bus_pkg::bus_data_t  p0_wdata,
    input  wire logic [3:0]                p0_wstrb,    // not used, full-word writes
    output logic                           p0_bvalid,
    input  wire logic                      p0_bready,
    output sound_bus_pkg::resp_t           p0_bresp,
    input  wire logic                      p0_arvalid,
    output logic                           p0_arready,
    input  wire sound_bus_pkg::bus_addr_t  p0_araddr,
    output logic                           p0_rvalid,
    input  wire logic                      p0_rready,
    output sound_bus_pkg::bus_data_t       p0_rdata,
    output sound_bus_pkg::resp_t           p0_rresp,
    input  wire logic                      p1_awvalid,
    output logic                           p1_awready,
    input  wire sound_bus_pkg::bus_addr_t  p1_awaddr,
    input  wire logic                      p1_wvalid,
    output logic                           p1_wready,
    input  wire sound_bus_pkg::bus_data_t  p1_wdata,
    input  wire logic [3:0]                p1_wstrb,    // not used, full-word writes
    output logic                           p1_bvalid,
    input  wire logic                      p1_bready,
    output sound_bus_pkg::resp_t           p1_bresp,
    input  wire logic                      p1_arvalid,
    output logic                           p1_arready,
    input  wire sound_bus_pkg::bus_addr_t  p1_araddr,
    output logic                           p1_rvalid,
    input  wire logic                      p1_rready,
    output sound_bus_pkg::bus_data_t       p1_rdata,
    output sound_bus_pkg::resp_t           p1_rresp,
    output logic                           reg_we,
    output logic                           reg_re,
    output sound_bus_pkg::reg_idx_t        reg_idx,
    output sound_bus_pkg::bus_data_t       reg_wdata,
    input  wire sound_bus_pkg::bus_data_t  reg_rdata
);

    sound_bus_pkg::arb_state_t state;
    logic                      last_grant;  // also the owner while not idle
    logic                      p0_wr_req;   // aw and w both present
    logic                      p1_wr_req;
    logic                      p0_req;
    logic                      p1_req;
    logic                      pick;        // winner seen in idle
    logic                      pick_wr;     // winner has a write, goes first
    logic                      bready_g;    // bready of the owner
    logic                      rready_g;
    sound_bus_pkg::bus_data_t  rdata_q;     // R channel payload

    assign p0_wr_req = p0_awvalid && p0_wvalid;
    assign p1_wr_req = p1_awvalid && p1_wvalid;
    assign p0_req    = p0_wr_req || p0_arvalid;
    assign p1_req    = p1_wr_req || p1_arvalid;
    assign pick      = (p0_req && p1_req) ? ~last_grant : p1_req;  // tie goes to other port
    assign pick_wr   = pick ? p1_wr_req : p0_wr_req;
    assign bready_g  = last_grant ? p1_bready : p0_bready;
    assign rready_g  = last_grant ? p1_rready : p0_rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= sound_bus_pkg::IDLE;
            last_grant <= 1'b1;                  // so port 0 wins the first tie
        end else begin
            case (state)
                sound_bus_pkg::IDLE: begin
                    if (p0_req || p1_req) begin
                        last_grant <= pick;
                        state      <= pick_wr ? sound_bus_pkg::WRITE : sound_bus_pkg::READ;
                    end
                end
                sound_bus_pkg::WRITE:      state <= sound_bus_pkg::WRITE_RESP;
                sound_bus_pkg::WRITE_RESP: if (bready_g) state <= sound_bus_pkg::IDLE;
                sound_bus_pkg::READ:       state <= sound_bus_pkg::READ_RESP;
                sound_bus_pkg::READ_RESP:  if (rready_g) state <= sound_bus_pkg::IDLE;
                default:                   state <= sound_bus_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reg_re) begin
            rdata_q <= reg_rdata;  // held until the R handshake
        end
    end

    // register bus, payload straight from the owner's held channels
    assign reg_we    = state == sound_bus_pkg::WRITE;
    assign reg_re    = state == sound_bus_pkg::READ;
    assign reg_wdata = last_grant ? p1_wdata : p0_wdata;
    assign reg_idx   = last_grant ? (reg_re ? p1_araddr[4:2] : p1_awaddr[4:2])
                                  : (reg_re ? p0_araddr[4:2] : p0_awaddr[4:2]);

    // aw and w accepted together
    assign p0_awready = reg_we && !last_grant;
    assign p0_wready  = p0_awready;
    assign p1_awready = reg_we && last_grant;
    assign p1_wready  = p1_awready;
    assign p0_arready = reg_re && !last_grant;
    assign p1_arready = reg_re && last_grant;

    assign p0_bvalid = (state == sound_bus_pkg::WRITE_RESP) && !last_grant;
    assign p1_bvalid = (state == sound_bus_pkg::WRITE_RESP) && last_grant;
    assign p0_rvalid = (state == sound_bus_pkg::READ_RESP) && !last_grant;
    assign p1_rvalid = (state == sound_bus_pkg::READ_RESP) && last_grant;
    assign p0_rdata  = rdata_q;
    assign p1_rdata  = rdata_q;
    assign p0_bresp  = `AXI_RESP_OKAY;  // no error cases in this window
    assign p1_bresp  = `AXI_RESP_OKAY;
    assign p0_rresp  = `AXI_RESP_OKAY;
    assign p1_rresp  = `AXI_RESP_OKAY;

    // ready only reaches a port that still presents that request
    a_accept_req: assert property (@(posedge clk) disable iff (rst)
        (!p0_awready || p0_wr_req) && (!p0_arready || p0_arvalid)
        && (!p1_awready || p1_wr_req) && (!p1_arready || p1_arvalid));

    a_p0_bhold: assert property (@(posedge clk) disable iff (rst)
        p0_bvalid && !p0_bready |=> p0_bvalid);

    a_p1_bhold: assert property (@(posedge clk) disable iff (rst)
        p1_bvalid && !p1_bready |=> p1_bvalid);

endmodule

`default_nettype wire

// ==== hdl/sn76477_core.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sound_consts.svh"

module sn76477_core (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire sound_types_pkg::freq_t      vco1_freq,
    input  wire sound_types_pkg::freq_t      vco2_freq,
    input  wire sound_types_pkg::freq_t      noise_freq,
    input  wire sound_types_pkg::lfo_freq_t  lfo_freq,
    input  wire sound_types_pkg::shift_t     lfo_shift,
    input  wire sound_types_pkg::mod_sel_t   mod_sel,
    input  wire sound_types_pkg::mix_t       mixer,
    output logic                             signal_out
);

    localparam int PS_W  = $clog2(`SND_PRESCALE);
    localparam int CNT_W = `SND_FREQ_W + 1;  // room for freq plus full lfo

    logic [PS_W-1:0]         ps_cnt;
    logic                    tick;          // one clk in every SND_PRESCALE
    logic [`SND_LFO_W-1:0]   lfo_div;       // ticks since last lfo step
    logic [`SND_LFO_W-1:0]   lfo;           // triangle value
    logic                    lfo_up;
    logic [`SND_LFO_W-1:0]   lfo_mod;       // lfo scaled by depth
    sound_types_pkg::freq_t  src_freq [3];  // vco1, vco2, noise
    logic [CNT_W-1:0]        src_limit [3];
    logic [CNT_W-1:0]        src_cnt [3];
    logic [2:0]              fire;          // source period elapsed
    logic                    vco1_q;
    logic                    vco2_q;
    sound_types_pkg::lfsr_t  lfsr;
    logic                    tone;          // or of enabled sources

    assign tick = ps_cnt == PS_W'(`SND_PRESCALE - 1);

    always_ff @(posedge clk) begin
        if (rst || tick) begin
            ps_cnt <= '0;
        end else begin
            ps_cnt <= ps_cnt + 1'b1;
        end
    end

    // up/down triangle, turns around at both ends
    always_ff @(posedge clk) begin
        if (rst) begin
            lfo_div <= '0;
            lfo     <= '0;
            lfo_up  <= 1'b1;
        end else if (tick) begin
            if (lfo_div >= lfo_freq) begin
                lfo_div <= '0;
                if (lfo_up ? &lfo : ~|lfo) begin
                    lfo_up <= ~lfo_up;
                    lfo    <= lfo_up ? lfo - 1'b1 : lfo + 1'b1;
                end else begin
                    lfo    <= lfo_up ? lfo + 1'b1 : lfo - 1'b1;
                end
            end else begin
                lfo_div <= lfo_div + 1'b1;
            end
        end
    end

    assign lfo_mod  = lfo >> lfo_shift;
    assign src_freq = '{vco1_freq, vco2_freq, noise_freq};

    // each source fires after freq + 1 + mod ticks
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            src_limit[i] = CNT_W'(src_freq[i]) + (mod_sel[i] ? CNT_W'(lfo_mod) : '0);
            fire[i]      = tick && (src_cnt[i] >= src_limit[i]);  // >= catches a lowered freq
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                src_cnt[i] <= '0;
            end
        end else if (tick) begin
            for (int i = 0; i < 3; i++) begin
                src_cnt[i] <= fire[i] ? '0 : src_cnt[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vco1_q <= 1'b0;
            vco2_q <= 1'b0;
            lfsr   <= 17'h1;    // any nonzero seed
        end else begin
            if (fire[0]) vco1_q <= ~vco1_q;
            if (fire[1]) vco2_q <= ~vco2_q;
            if (fire[2]) lfsr <= {lfsr[15:0], lfsr[16] ^ lfsr[13]};  // x^17 + x^14 + 1
        end
    end

    assign tone       = |({lfsr[0], vco2_q, vco1_q} & mixer[2:0]);
    assign signal_out = tone && (!mixer[3] || lfo[`SND_LFO_W-1]);  // lfo msb gates

endmodule

`default_nettype wire

// ==== hdl/sound_bus_pkg.sv ====
`default_nettype none

package sound_bus_pkg;

    typedef logic [15:0] bus_addr_t;  // axi byte address
    typedef logic [31:0] bus_data_t;
    typedef logic [2:0]  reg_idx_t;   // address bits 4:2
    typedef logic [1:0]  resp_t;

    // one transaction at a time, grant held through the response
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WRITE_RESP,
        READ,
        READ_RESP
    } arb_state_t;

endpackage

`default_nettype wire

// ==== hdl/sound_io_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sound_io_top (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      p0_awvalid,  // cpu port
    output logic                           p0_awready,
    input  wire sound_bus_pkg::bus_addr_t  p0_awaddr,
    input  wire logic                      p0_wvalid,
    output logic                           p0_wready,
    input  wire sound_bus_pkg::bus_data_t  p0_wdata,
    input  wire logic [3:0]                p0_wstrb,
    output logic                           p0_bvalid,
    input  wire logic                      p0_bready,
    output sound_bus_pkg::resp_t           p0_bresp,
    input  wire logic                      p0_arvalid,
    output logic                           p0_arready,
    input  wire sound_bus_pkg::bus_addr_t  p0_araddr,
    output logic                           p0_rvalid,
    input  wire logic                      p0_rready,
    output sound_bus_pkg::bus_data_t       p0_rdata,
    output sound_bus_pkg::resp_t           p0_rresp,
    input  wire logic                      p1_awvalid,  // second master
    output logic                           p1_awready,
    input  wire sound_bus_pkg::bus_addr_t  p1_awaddr,
    input  wire logic                      p1_wvalid,
    output logic                           p1_wready,
    input  wire sound_bus_pkg::bus_data_t  p1_wdata,
    input  wire logic [3:0]                p1_wstrb,
    output logic                           p1_bvalid,
    input  wire logic                      p1_bready,
    output sound_bus_pkg::resp_t           p1_bresp,
    input  wire logic                      p1_arvalid,
    output logic                           p1_arready,
    input  wire sound_bus_pkg::bus_addr_t  p1_araddr,
    output logic                           p1_rvalid,
    input  wire logic                      p1_rready,
    output sound_bus_pkg::bus_data_t       p1_rdata,
    output sound_bus_pkg::resp_t           p1_rresp,
    output logic                           signal_out   // one-bit sound
);

    // internal register bus
    logic                       reg_we;
    logic                       reg_re;
    sound_bus_pkg::reg_idx_t    reg_idx;
    sound_bus_pkg::bus_data_t   reg_wdata;
    sound_bus_pkg::bus_data_t   reg_rdata;

    // sound controls into the core
    sound_types_pkg::freq_t     vco1_freq;
    sound_types_pkg::freq_t     vco2_freq;
    sound_types_pkg::freq_t     noise_freq;
    sound_types_pkg::lfo_freq_t lfo_freq;
    sound_types_pkg::shift_t    lfo_shift;
    sound_types_pkg::mod_sel_t  mod_sel;
    sound_types_pkg::mix_t      mixer;

    axil_arbiter u_arbiter (.*);  // ports match by name
    sound_regs   u_regs    (.*);
    sn76477_core u_core    (.*);

endmodule

`default_nettype wire

// ==== hdl/sound_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sound_consts.svh"

module sound_regs (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      reg_we,
    input  wire logic                      reg_re,
    input  wire sound_bus_pkg::reg_idx_t   reg_idx,
    input  wire sound_bus_pkg::bus_data_t  reg_wdata,
    output sound_bus_pkg::bus_data_t       reg_rdata,
    output sound_types_pkg::freq_t         vco1_freq,
    output sound_types_pkg::freq_t         vco2_freq,
    output sound_types_pkg::freq_t         noise_freq,
    output sound_types_pkg::lfo_freq_t     lfo_freq,
    output sound_types_pkg::shift_t        lfo_shift,
    output sound_types_pkg::mod_sel_t      mod_sel,    // {noise, vco2, vco1}
    output sound_types_pkg::mix_t          mixer       // {lfo, noise, vco2, vco1}
);

    // write decode, upper data bits dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            vco1_freq  <= '0;
            vco2_freq  <= '0;
            noise_freq <= '0;
            lfo_freq   <= '0;
            lfo_shift  <= '0;
            mod_sel    <= '0;
            mixer      <= '0;  // silent out of reset
        end else if (reg_we) begin
            case (reg_idx)
                `SND_REG_VCO1:   vco1_freq  <= reg_wdata[`SND_FREQ_W-1:0];
                `SND_REG_VCO2:   vco2_freq  <= reg_wdata[`SND_FREQ_W-1:0];
                `SND_REG_NOISE:  noise_freq <= reg_wdata[`SND_FREQ_W-1:0];
                `SND_REG_LFO:    lfo_freq   <= reg_wdata[`SND_LFO_W-1:0];
                `SND_REG_DEPTH:  lfo_shift  <= reg_wdata[`SND_SHIFT_W-1:0];
                `SND_REG_MODSEL: mod_sel    <= reg_wdata[`SND_MOD_W-1:0];
                `SND_REG_MIXER:  mixer      <= reg_wdata[`SND_MIX_W-1:0];
                default: ;                  // index 7 is a hole
            endcase
        end
    end

    // read mux, fields zero-extended
    always_comb begin
        reg_rdata = '0;
        if (reg_re) begin
            case (reg_idx)
                `SND_REG_VCO1:   reg_rdata[`SND_FREQ_W-1:0]  = vco1_freq;
                `SND_REG_VCO2:   reg_rdata[`SND_FREQ_W-1:0]  = vco2_freq;
                `SND_REG_NOISE:  reg_rdata[`SND_FREQ_W-1:0]  = noise_freq;
                `SND_REG_LFO:    reg_rdata[`SND_LFO_W-1:0]   = lfo_freq;
                `SND_REG_DEPTH:  reg_rdata[`SND_SHIFT_W-1:0] = lfo_shift;
                `SND_REG_MODSEL: reg_rdata[`SND_MOD_W-1:0]   = mod_sel;
                `SND_REG_MIXER:  reg_rdata[`SND_MIX_W-1:0]   = mixer;
                default: ;                  // unmapped reads 0
            endcase
        end
    end

    // the arbiter must present a real index with every write
    a_idx_known: assert property (@(posedge clk) disable iff (rst)
        reg_we |-> !$isunknown(reg_idx));

endmodule

`default_nettype wire

// ==== hdl/sound_types_pkg.sv ====
`default_nettype none
`include "sound_consts.svh"

package sound_types_pkg;

    typedef logic [`SND_FREQ_W-1:0]  freq_t;      // oscillator half-period, in ticks
    typedef logic [`SND_LFO_W-1:0]   lfo_freq_t;  // ticks per lfo step
    typedef logic [`SND_SHIFT_W-1:0] shift_t;     // lfo depth as right shift
    typedef logic [`SND_MOD_W-1:0]   mod_sel_t;   // {noise, vco2, vco1}
    typedef logic [`SND_MIX_W-1:0]   mix_t;       // {lfo, noise, vco2, vco1}
    typedef logic [16:0]             lfsr_t;      // noise shift register

endpackage

`default_nettype wire

// ==== include/sound_consts.svh ====
`ifndef SOUND_CONSTS_SVH
`define SOUND_CONSTS_SVH

// field widths
`define SND_FREQ_W  12
`define SND_LFO_W   10
`define SND_SHIFT_W 3
`define SND_MOD_W   3
`define SND_MIX_W   4

// register index, taken from offset bits 4:2
`define SND_REG_VCO1   3'd0
`define SND_REG_VCO2   3'd1
`define SND_REG_NOISE  3'd2
`define SND_REG_LFO    3'd3
`define SND_REG_DEPTH  3'd4
`define SND_REG_MODSEL 3'd5
`define SND_REG_MIXER  3'd6

`define SND_PRESCALE 4        // clk cycles per synthesis tick

`define AXI_RESP_OKAY 2'b00

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sound peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_sound_io -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1

// ==== include/sound_tb_consts.svh ====
`ifndef SOUND_TB_CONSTS_SVH
`define SOUND_TB_CONSTS_SVH

// test lengths, in clk cycles unless noted
`define TB_RESET_WATCH 200   // quiet window after reset
`define TB_RAND_WRITES 40    // per port
`define TB_MOD_GAPS    32    // edge gaps sampled with lfo stretch
`define TB_GATE_WINDOW 12000 // longer than one full lfo period

`endif

// ==== verification/tb_sound_io.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "sound_consts.svh"
`include "sound_tb_consts.svh"

module tb_sound_io;

    // bus budget, tone gaps, modulated gaps, gating window, plus margin
    localparam int TIMEOUT_CYCLES = `TB_RESET_WATCH + 250 * 10 + 12 * 84
                                    + `TB_MOD_GAPS * (6 + 64) * `SND_PRESCALE
                                    + `TB_GATE_WINDOW + 2000;

    logic        clk;
    logic        rst;
    logic        awvalid [2];
    logic        awready [2];
    logic [15:0] awaddr  [2];
    logic        wvalid  [2];
    logic        wready  [2];
    logic [31:0] wdata   [2];
    logic        bvalid  [2];
    logic        bready  [2];
    logic [1:0]  bresp   [2];
    logic        arvalid [2];
    logic        arready [2];
    logic [15:0] araddr  [2];
    logic        rvalid  [2];
    logic        rready  [2];
    logic [31:0] rdata   [2];
    logic [1:0]  rresp   [2];
    logic        signal_out;

    int          errors;
    int          cycles;
    logic [31:0] lcg_state;
    logic [31:0] mirror [8];   // expected register contents
    int          last_port;    // port granted last, for the tie rule

    sound_io_top u_dut (
        .clk(clk), .rst(rst),
        .p0_awvalid(awvalid[0]), .p0_awready(awready[0]), .p0_awaddr(awaddr[0]),
        .p0_wvalid(wvalid[0]), .p0_wready(wready[0]), .p0_wdata(wdata[0]),
        .p0_wstrb(4'hf), .p0_bvalid(bvalid[0]), .p0_bready(bready[0]),
        .p0_bresp(bresp[0]), .p0_arvalid(arvalid[0]), .p0_arready(arready[0]),
        .p0_araddr(araddr[0]), .p0_rvalid(rvalid[0]), .p0_rready(rready[0]),
        .p0_rdata(rdata[0]), .p0_rresp(rresp[0]),
        .p1_awvalid(awvalid[1]), .p1_awready(awready[1]), .p1_awaddr(awaddr[1]),
        .p1_wvalid(wvalid[1]), .p1_wready(wready[1]), .p1_wdata(wdata[1]),
        .p1_wstrb(4'hf), .p1_bvalid(bvalid[1]), .p1_bready(bready[1]),
        .p1_bresp(bresp[1]), .p1_arvalid(arvalid[1]), .p1_arready(arready[1]),
        .p1_araddr(araddr[1]), .p1_rvalid(rvalid[1]), .p1_rready(rready[1]),
        .p1_rdata(rdata[1]), .p1_rresp(rresp[1]),
        .signal_out(signal_out)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // readback expected after writing data to idx
    function automatic logic [31:0] model_reg(input int idx, input logic [31:0] data);
        case (idx)
            0, 1, 2: return data & ((32'd1 << `SND_FREQ_W) - 1);  // vco1, vco2, noise
            3:       return data & ((32'd1 << `SND_LFO_W) - 1);
            4:       return data & ((32'd1 << `SND_SHIFT_W) - 1);
            5:       return data & ((32'd1 << `SND_MOD_W) - 1);
            6:       return data & ((32'd1 << `SND_MIX_W) - 1);
            default: return 32'd0;                                // hole
        endcase
    endfunction

    function automatic int expected_half_period(input int freq);
        return (freq + 1) * `SND_PRESCALE;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // all host tasks start and end 2 ns after a rising edge
    task automatic axi_write(input int p, input int idx, input logic [31:0] data);
        awvalid[p] = 1'b1;
        wvalid[p]  = 1'b1;
        awaddr[p]  = 16'(idx << 2);
        wdata[p]   = data;
        bready[p]  = 1'b1;
        do @(negedge clk); while (!awready[p]);  // handshake on next edge
        check("wready", wready[p], 1'b1);
        last_port = p;
        @(posedge clk);
        #2;
        awvalid[p] = 1'b0;
        wvalid[p]  = 1'b0;
        while (!bvalid[p]) @(negedge clk);
        check("bresp", bresp[p], `AXI_RESP_OKAY);
        @(posedge clk);
        #2;
        bready[p] = 1'b0;
    endtask

    task automatic axi_read(input int p, input int idx, output logic [31:0] data);
        arvalid[p] = 1'b1;
        araddr[p]  = 16'(idx << 2);
        rready[p]  = 1'b1;
        do @(negedge clk); while (!arready[p]);
        last_port = p;
        @(posedge clk);
        #2;
        arvalid[p] = 1'b0;
        while (!rvalid[p]) @(negedge clk);
        data = rdata[p];
        check("rresp", rresp[p], `AXI_RESP_OKAY);
        @(posedge clk);
        #2;
        rready[p] = 1'b0;
    endtask

    // clk cycles between the next two edges of signal_out
    task automatic edge_gap(output int gap);
        logic prev;
        @(negedge clk);
        prev = signal_out;
        while (signal_out == prev) @(negedge clk);  // first edge
        prev = signal_out;
        gap  = 0;
        while (signal_out == prev) begin
            @(negedge clk);
            gap++;
        end
    endtask

    task automatic resync();
        @(posedge clk);
        #2;
    endtask

    task automatic tone_period(input int freq);
        int gap;
        axi_write(0, `SND_REG_VCO1, freq);
        repeat (2) edge_gap(gap);  // let the old period drain
        repeat (4) begin
            edge_gap(gap);
            check("signal_out gap", gap, expected_half_period(freq));
        end
        resync();
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] exp;
        int          idx;
        int          gap;
        int          longer;
        int          quiet;
        int          longest;
        int          edges;
        logic        prev;

        clk       = 1'b0;
        rst       = 1'b1;
        errors    = 0;
        lcg_state = 32'd11;
        last_port = 1;      // port 0 takes the first tie
        for (int p = 0; p < 2; p++) begin
            awvalid[p] = 1'b0;
            awaddr[p]  = '0;
            wvalid[p]  = 1'b0;
            wdata[p]   = '0;
            bready[p]  = 1'b0;
            arvalid[p] = 1'b0;
            araddr[p]  = '0;
            rready[p]  = 1'b0;
        end
        for (int i = 0; i < 8; i++) mirror[i] = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // reset state
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 8; i++) begin
                axi_read(p, i, d);
                check("rdata after reset", d, 32'd0);
            end
        end
        repeat (`TB_RESET_WATCH) begin
            @(negedge clk);
            check("signal_out", signal_out, 1'b0);
        end
        resync();

        // random write then readback, on each port
        for (int p = 0; p < 2; p++) begin
            repeat (`TB_RAND_WRITES) begin
                idx = lcg_next() % 8;
                d   = lcg_next();
                axi_write(p, idx, d);
                if (idx < 7) mirror[idx] = model_reg(idx, d);
                axi_read(p, idx, d0);
                check("rdata vs model", d0, model_reg(idx, d));
                check("rdata vs mirror", d0, mirror[idx]);
            end
        end

        // same-cycle writes, three rounds of ties
        repeat (3) begin
            d0  = lcg_next();
            d1  = lcg_next();
            exp = (last_port == 0) ? d0 : d1;  // loser of the tie writes last
            fork
                axi_write(0, `SND_REG_VCO2, d0);
                axi_write(1, `SND_REG_VCO2, d1);
            join
            mirror[`SND_REG_VCO2] = model_reg(`SND_REG_VCO2, exp);
            axi_read(0, `SND_REG_VCO2, d);
            check("vco2 after tie", d, mirror[`SND_REG_VCO2]);
        end

        // port 0 stalls its B channel with a port 1 read waiting
        awvalid[0] = 1'b1;
        wvalid[0]  = 1'b1;
        awaddr[0]  = 16'(`SND_REG_LFO << 2);
        wdata[0]   = 32'h0000_0000;     // fastest lfo
        bready[0]  = 1'b0;
        do @(negedge clk); while (!awready[0]);
        last_port = 0;
        resync();
        awvalid[0] = 1'b0;
        wvalid[0]  = 1'b0;
        mirror[`SND_REG_LFO] = 32'd0;
        fork
            axi_read(1, `SND_REG_LFO, d);
            begin
                repeat (10) begin
                    @(negedge clk);
                    check("p0_bvalid", bvalid[0], 1'b1);
                    check("p1_arready", arready[1], 1'b0);
                end
                resync();
                bready[0] = 1'b1;
                @(negedge clk);
                check("p0_bvalid", bvalid[0], 1'b1);
                check("p1_arready", arready[1], 1'b0);
                resync();
                bready[0] = 1'b0;
            end
        join
        check("lfo readback", d, mirror[`SND_REG_LFO]);

        // plain tone on vco1
        axi_write(0, `SND_REG_MODSEL, 0);
        axi_write(0, `SND_REG_MIXER, 1);
        tone_period(5);
        tone_period(20);
        tone_period(5);

        // lfo stretches vco1, never shortens it
        axi_write(0, `SND_REG_DEPTH, 4);
        axi_write(0, `SND_REG_MODSEL, 1);
        longer = 0;
        repeat (`TB_MOD_GAPS) begin
            edge_gap(gap);
            if (gap > expected_half_period(5)) longer++;
            if (gap < expected_half_period(5)) begin
                $display("modulated edge spacing of %0d cycles is shorter than the tone", gap);
                errors++;
            end
        end
        if (longer == 0) begin
            $display("lfo modulation never stretched the vco1 period");
            errors++;
        end
        resync();

        // lfo msb gates the tone
        axi_write(0, `SND_REG_MODSEL, 0);
        axi_write(0, `SND_REG_MIXER, 9);  // lfo gate plus vco1
        longest = 0;
        quiet   = 0;
        edges   = 0;
        @(negedge clk);
        prev = signal_out;
        repeat (`TB_GATE_WINDOW) begin
            @(negedge clk);
            if (signal_out != prev) begin
                edges++;
                quiet = 0;
            end else begin
                quiet++;
            end
            if (quiet > longest) longest = quiet;
            prev = signal_out;
        end
        if (edges == 0) begin
            $display("gated tone never sounded while the lfo msb was high");
            errors++;
        end
        if (longest < ((1 << (`SND_LFO_W - 1)) - 1) * `SND_PRESCALE) begin
            $display("no silent stretch of an lfo half-cycle, longest was %0d cycles", longest);
            errors++;
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
